// ==== include/timekeeper_consts.svh ====
//////////////////////////////////////////////////////////////////////
// timekeeper constants
// settings register map, readback map and the time step
//////////////////////////////////////////////////////////////////////

`ifndef TIMEKEEPER_CONSTS_SVH
`define TIMEKEEPER_CONSTS_SVH

// settings bus addresses
// load time is written hi, then lo, then ctrl
`define SR_TIME_HI   0
`define SR_TIME_LO   1
`define SR_TIME_CTRL 2
// divider for the tick strobe
`define SR_TICK_DIV  3

// readback addresses
`define RB_TIME_NOW  0
`define RB_TIME_PPS  1

// time added per tick strobe
`define TIME_INCREMENT_DEFAULT 1

`endif

// ==== rtl/settings_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// settings bus types
// write strobe bus from software and the readback pair
//////////////////////////////////////////////////////////////////////

`default_nettype none

package settings_pkg;

   // one-cycle write strobe with address and data
   typedef struct packed {
      logic        stb;
      logic [7:0]  addr;
      logic [31:0] data;
   } set_bus_t;

   // readback select and the 64-bit word behind it
   // only data leaves the block
   typedef struct packed {
      logic [7:0]  addr;
      logic [63:0] data;
   } rb_bus_t;

endpackage

`default_nettype wire

// ==== rtl/time_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// time types
// time value, load control word, status and divider value
//////////////////////////////////////////////////////////////////////

`default_nettype none

package time_pkg;

   // full time value and one 32-bit half of it
   typedef logic [63:0] vita_time_t;
   typedef logic [31:0] time_half_t;

   // load event select, msb first: sync, pps, now
   typedef struct packed {
      logic sync;
      logic pps;
      logic now;
   } time_ctrl_t;

   // what the timekeeper exposes for readback
   typedef struct packed {
      vita_time_t now;
      vita_time_t last_pps;
   } time_status_t;

   // tick divider, strobe every div+1 cycles
   typedef logic [15:0] tick_div_t;

endpackage

`default_nettype wire

// ==== rtl/setting_reg.sv ====
//////////////////////////////////////////////////////////////////////
// settings register
// holds one payload written over the settings bus, pulses on write
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module setting_reg #(
   parameter int  addr = 0,
   parameter type T    = logic [31:0]
) (
   input  wire logic                  clk,
   input  wire logic                  reset,
   input  wire settings_pkg::set_bus_t set,
   output T                           value,
   output logic                       changed
);

   // payload width, taken from the low bits of data
   localparam int W = $bits(T);

   logic hit;

   // a write is ours when the strobe is up and the address matches
   assign hit = set.stb && (set.addr == 8'(addr));

   ///////////////////////////////////////////////////////////////////
   // payload and change pulse
   ///////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         value   <= T'('0);
         changed <= 1'b0;
      end else begin
         // changed lines up with the first cycle of the new value
         changed <= hit;
         if (hit) begin
            value <= T'(set.data[W-1:0]);
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/tick_divider.sv ====
//////////////////////////////////////////////////////////////////////
// tick divider
// down-counter making a one-cycle strobe every div+1 cycles
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module tick_divider (
   input  wire logic                clk,
   input  wire logic                reset,
   input  wire time_pkg::tick_div_t div,
   input  wire logic                div_changed,
   output logic                     strobe
);

   time_pkg::tick_div_t count;
   logic                at_zero;

   assign at_zero = (count == '0);

   // strobe on the zero state of the counter
   // with div of 0 the counter stays at zero, so every cycle strobes
   assign strobe = at_zero;

   ///////////////////////////////////////////////////////////////////
   // counter
   ///////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (div_changed) begin
         // new rate, start a full period from here
         count <= div;
      end else if (at_zero) begin
         count <= div;
      end else begin
         count <= count - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/timekeeper.sv ====
//////////////////////////////////////////////////////////////////////
// timekeeper
// 64-bit time counter with armed load on now, pps or sync events,
// and capture of the time at the last pps edge
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "timekeeper_consts.svh"

module timekeeper #(
   parameter time_pkg::vita_time_t INCREMENT = 64'(`TIME_INCREMENT_DEFAULT)
) (
   input  wire logic                 clk,
   input  wire logic                 reset,
   input  wire logic                 pps,
   input  wire logic                 sync_in,
   input  wire logic                 strobe,
   input  wire time_pkg::vita_time_t next_time,
   input  wire time_pkg::time_ctrl_t ctrl,
   input  wire logic                 ctrl_changed,
   output time_pkg::time_status_t    status,
   output logic                      sync_out
);

   ///////////////////////////////////////////////////////////////////
   // pps synchronizer and rising edge
   ///////////////////////////////////////////////////////////////////
   // [0] and [1] are the sync pair, [2] is the delayed copy
   logic [2:0] pps_sync;
   logic       pps_edge;
   // sync input is registered once before use
   logic       sync_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         pps_sync <= '0;
         sync_q   <= 1'b0;
      end else begin
         pps_sync <= {pps_sync[1:0], pps};
         sync_q   <= sync_in;
      end
   end

   // high for one cycle, two edges after pps was first seen high
   assign pps_edge = pps_sync[1] & ~pps_sync[2];

   ///////////////////////////////////////////////////////////////////
   // arming
   ///////////////////////////////////////////////////////////////////
   logic armed;
   logic time_event;

   // load fires once per ctrl write, on whichever event ctrl selects
   assign time_event = armed &&
                       (ctrl.now || (ctrl.pps && pps_edge) || (ctrl.sync && sync_q));

   always_ff @(posedge clk) begin
      if (reset) begin
         armed <= 1'b0;
      end else if (ctrl_changed) begin
         armed <= 1'b1;
      end else if (time_event) begin
         armed <= 1'b0;
      end
   end

   ///////////////////////////////////////////////////////////////////
   // time counter and last pps capture
   ///////////////////////////////////////////////////////////////////
   always_ff @(posedge clk) begin
      if (reset) begin
         status   <= '0;
         sync_out <= 1'b0;
      end else begin
         // one cycle pulse, same cycle the loaded time shows up
         sync_out <= time_event;
         if (time_event) begin
            status.now <= next_time;
         end else if (strobe) begin
            status.now <= status.now + INCREMENT;
         end
         // a load on the pps edge itself is what software sees there
         if (pps_edge) begin
            if (time_event) begin
               status.last_pps <= next_time;
            end else begin
               status.last_pps <= status.now + INCREMENT;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/time_readback.sv ====
//////////////////////////////////////////////////////////////////////
// time readback
// registered selector over current time and last pps time
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "timekeeper_consts.svh"

module time_readback (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire logic [7:0]             rb_addr,
   input  wire time_pkg::time_status_t status,
   output time_pkg::vita_time_t        rb_data
);

   // select stage, address and the word it picks
   settings_pkg::rb_bus_t rb_sel;

   always_comb begin
      rb_sel.addr = rb_addr;
      case (rb_sel.addr)
         8'(`RB_TIME_NOW): rb_sel.data = status.now;
         8'(`RB_TIME_PPS): rb_sel.data = status.last_pps;
         // unmapped reads return zero
         default:          rb_sel.data = '0;
      endcase
   end

   // hold the word so a 64-bit read is one consistent snapshot
   always_ff @(posedge clk) begin
      if (reset) begin
         rb_data <= '0;
      end else begin
         rb_data <= rb_sel.data;
      end
   end

endmodule

`default_nettype wire

// ==== rtl/timekeeper_top.sv ====
//////////////////////////////////////////////////////////////////////
// timekeeper top
// settings registers, tick divider, timekeeper and readback
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "timekeeper_consts.svh"

module timekeeper_top (
   input  wire logic                   clk,
   input  wire logic                   reset,
   input  wire settings_pkg::set_bus_t set,
   input  wire logic [7:0]             rb_addr,
   input  wire logic                   pps,
   input  wire logic                   sync_in,
   output time_pkg::vita_time_t        rb_data,
   output logic                        sync_out
);

   time_pkg::time_half_t   time_hi;
   time_pkg::time_half_t   time_lo;
   time_pkg::time_ctrl_t   time_ctrl;
   logic                   ctrl_changed;
   time_pkg::tick_div_t    tick_div;
   logic                   div_changed;
   logic                   strobe;
   time_pkg::time_status_t status;

   ///////////////////////////////////////////////////////////////////
   // settings registers
   ///////////////////////////////////////////////////////////////////
   // load time halves, only the ctrl write starts a load
   setting_reg #(.addr(`SR_TIME_HI), .T(time_pkg::time_half_t)) sr_time_hi (
      .clk(clk), .reset(reset), .set(set), .value(time_hi), .changed());

   setting_reg #(.addr(`SR_TIME_LO), .T(time_pkg::time_half_t)) sr_time_lo (
      .clk(clk), .reset(reset), .set(set), .value(time_lo), .changed());

   setting_reg #(.addr(`SR_TIME_CTRL), .T(time_pkg::time_ctrl_t)) sr_time_ctrl (
      .clk(clk), .reset(reset), .set(set), .value(time_ctrl), .changed(ctrl_changed));

   setting_reg #(.addr(`SR_TICK_DIV), .T(time_pkg::tick_div_t)) sr_tick_div (
      .clk(clk), .reset(reset), .set(set), .value(tick_div), .changed(div_changed));

   // tick strobe for the time counter
   tick_divider tick_divider_i (
      .clk(clk), .reset(reset), .div(tick_div), .div_changed(div_changed),
      .strobe(strobe));

   timekeeper #(.INCREMENT(64'(`TIME_INCREMENT_DEFAULT))) timekeeper_i (
      .clk(clk), .reset(reset), .pps(pps), .sync_in(sync_in), .strobe(strobe),
      .next_time({time_hi, time_lo}), .ctrl(time_ctrl), .ctrl_changed(ctrl_changed),
      .status(status), .sync_out(sync_out));

   time_readback time_readback_i (
      .clk(clk), .reset(reset), .rb_addr(rb_addr), .status(status), .rb_data(rb_data));

endmodule

`default_nettype wire

// ==== verif/timekeeper_tb_checks.sv ====
//////////////////////////////////////////////////////////////////////
// timekeeper checker
// value and range assertions, sync_out monitor, failure flag
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

module timekeeper_tb_checks (
   input  wire logic clk,
   input  wire logic reset,
   input  wire logic sync_out,
   input  wire logic sync_allowed,
   output logic      error
);

   initial error = 1'b0;

   // wrong value, shows time, signal and both values
   task automatic value_failed(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
      $display("CHECK FAILED time %0t %s expected %0h actual %0h",
               $time, name, expected, actual);
      error = 1'b1;
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      assert (actual === expected) else value_failed(name, expected, actual);
   endtask

   // inclusive window, lo and hi both allowed
   task automatic check_range(input string name, input logic [63:0] lo,
                              input logic [63:0] hi, input logic [63:0] actual);
      assert (actual >= lo && actual <= hi) else begin
         $display("CHECK FAILED time %0t %s expected %0h to %0h actual %0h",
                  $time, name, lo, hi, actual);
         error = 1'b1;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("timed out at time %0t while waiting for %s", $time, what);
      error = 1'b1;
   endtask

   ///////////////////////////////////////////////////////////////////
   // sync_out monitor
   ///////////////////////////////////////////////////////////////////
   // outside an expected load window sync_out has to stay low
   always @(posedge clk) begin
      if (!reset && !sync_allowed) begin
         assert (sync_out === 1'b0) else value_failed("sync_out", 64'd0, 64'(sync_out));
      end
   end

endmodule

`default_nettype wire

// ==== verif/timekeeper_tb.sv ====
//////////////////////////////////////////////////////////////////////
// timekeeper testbench
// clock, reset, lfsr, settings bus stimulus and the test flow
//////////////////////////////////////////////////////////////////////

`timescale 1ns/10ps
`default_nettype none

`include "timekeeper_consts.svh"

module timekeeper_tb;

   logic                   clk;
   logic                   reset;
   settings_pkg::set_bus_t set;
   logic [7:0]             rb_addr;
   logic                   pps;
   logic                   sync_in;
   time_pkg::vita_time_t   rb_data;
   logic                   sync_out;
   logic                   sync_allowed;
   logic                   error;
   logic [31:0]            lfsr_state;

   // 4 ns period
   always #2 clk = ~clk;

   timekeeper_top DUT (
      .clk(clk), .reset(reset), .set(set), .rb_addr(rb_addr), .pps(pps),
      .sync_in(sync_in), .rb_data(rb_data), .sync_out(sync_out));

   timekeeper_tb_checks checks (
      .clk(clk), .reset(reset), .sync_out(sync_out), .sync_allowed(sync_allowed),
      .error(error));

   // first failed check ends the run
   always @(posedge error) begin
      $display("Some tests failed");
      $fatal(1, "stopped on first error");
   end

   // fibonacci lfsr, taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one step per bit taken
   function automatic logic [63:0] random_bits(input int n);
      logic [63:0] v;
      v = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_step(lfsr_state);
         v = {v[62:0], lfsr_state[0]};
      end
      return v;
   endfunction

   ///////////////////////////////////////////////////////////////////
   // stimulus tasks, all start and end on a falling edge
   ///////////////////////////////////////////////////////////////////
   task automatic write_setting(input logic [7:0] addr, input logic [31:0] data);
      set.stb  = 1'b1;
      set.addr = addr;
      set.data = data;
      @(negedge clk);
      set.stb  = 1'b0;
   endtask

   // hi, lo, then ctrl arms the load
   task automatic stage_time(input time_pkg::vita_time_t t, input logic [2:0] ctrl);
      write_setting(`SR_TIME_HI, t[63:32]);
      write_setting(`SR_TIME_LO, t[31:0]);
      write_setting(`SR_TIME_CTRL, {29'd0, ctrl});
   endtask

   // address goes out now, data is valid one edge later
   task automatic read_time(input logic [7:0] addr, output time_pkg::vita_time_t t);
      rb_addr = addr;
      @(negedge clk);
      t = rb_data;
   endtask

   task automatic wait_cycles(input int n);
      repeat (n) @(negedge clk);
   endtask

   // falling edges until sync_out shows up
   task automatic wait_sync(output int n);
      n = 0;
      while (sync_out !== 1'b1 && n < 20) begin
         @(negedge clk);
         n++;
      end
      if (sync_out !== 1'b1) checks.report_timeout("sync_out");
   endtask

   initial begin
      time_pkg::vita_time_t t0;
      time_pkg::vita_time_t t1;
      time_pkg::vita_time_t tp;
      time_pkg::vita_time_t v;
      logic [15:0]          d;
      int                   k;
      int                   n;
      clk          = 1'b0;
      reset        = 1'b1;
      set          = '0;
      rb_addr      = `RB_TIME_NOW;
      pps          = 1'b0;
      sync_in      = 1'b0;
      sync_allowed = 1'b0;
      lfsr_state   = 32'h3f04;
      repeat (10) @(negedge clk);
      reset = 1'b0;

      // both readback words start at zero
      read_time(`RB_TIME_NOW, t0);
      checks.check_value("rb_data", 64'd0, t0);
      read_time(`RB_TIME_PPS, t0);
      checks.check_value("rb_data", 64'd0, t0);

      // tick rate, k edges give k/(D+1) strobes or one more
      d = 16'(random_bits(3));
      k = 4 + int'(random_bits(5));
      write_setting(`SR_TICK_DIV, {16'd0, d});
      wait_cycles(2);
      read_time(`RB_TIME_NOW, t0);
      wait_cycles(k - 1);
      read_time(`RB_TIME_NOW, t1);
      checks.check_range("rb_data", t0 + k / (d + 1), t0 + k / (d + 1) + 1, t1);

      // immediate load, sync_out two edges after the ctrl write
      v = random_bits(64);
      sync_allowed = 1'b1;
      stage_time(v, 3'b001);
      wait_sync(n);
      checks.check_value("sync_out delay", 64'd2, 64'(n));
      read_time(`RB_TIME_NOW, t1);
      checks.check_range("rb_data", v, v + 1, t1);
      sync_allowed = 1'b0;

      // pps load, must hold off until the pps rise
      v = random_bits(64);
      stage_time(v, 3'b010);
      wait_cycles(6);
      sync_allowed = 1'b1;
      pps = 1'b1;
      @(negedge clk);
      wait_sync(n);
      checks.check_value("sync_out delay", 64'd2, 64'(n));
      read_time(`RB_TIME_PPS, tp);
      checks.check_value("rb_data", v, tp);
      sync_allowed = 1'b0;
      pps = 1'b0;

      // unarmed pps, strobe every cycle so the capture sits inside the reads
      write_setting(`SR_TICK_DIV, 32'd0);
      wait_cycles(2);
      read_time(`RB_TIME_NOW, t0);
      pps = 1'b1;
      wait_cycles(4);
      pps = 1'b0;
      read_time(`RB_TIME_NOW, t1);
      read_time(`RB_TIME_PPS, tp);
      checks.check_range("rb_data", t0, t1, tp);

      // sync load fires one edge after sync_in
      v = random_bits(64);
      stage_time(v, 3'b100);
      wait_cycles(4);
      sync_allowed = 1'b1;
      sync_in = 1'b1;
      @(negedge clk);
      wait_sync(n);
      checks.check_value("sync_out delay", 64'd1, 64'(n));
      read_time(`RB_TIME_NOW, t1);
      checks.check_value("rb_data", v, t1);
      sync_allowed = 1'b0;
      sync_in = 1'b0;
      wait_cycles(3);
      // second sync with no new ctrl write stays quiet
      sync_in = 1'b1;
      wait_cycles(3);
      sync_in = 1'b0;
      wait_cycles(4);

      if (error) begin
         $display("Some tests failed");
         $fatal(1, "errors seen during the run");
      end else begin
         $display("All tests passed");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== tb.f ====
+incdir+include
rtl/settings_pkg.sv
rtl/time_pkg.sv
rtl/setting_reg.sv
rtl/tick_divider.sv
rtl/timekeeper.sv
rtl/time_readback.sv
rtl/timekeeper_top.sv
verif/timekeeper_tb_checks.sv
verif/timekeeper_tb.sv
